/* compile.f */
design/wbd_pkg.sv
design/wbd_beat_issuer.sv
design/wbd_ack_fifo.sv
design/wbd_read_merge.sv
design/wbd_top.sv
bench/tb_clock.sv
bench/wbd_sva.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the downconverter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top --Mdir obj_dir -o tb_sim \
	-f compile.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

/* bench/tb_top.sv */
`timescale 1ns/1ps

module tb_top import wbd_pkg::*;
();

	localparam int CYCLE_LIMIT = 20000;
	localparam int MEM_WORDS   = 128;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_wcyc;
	logic        i_wstb;
	logic        i_wwe;
	wide_addr_t  i_waddr;
	wide_data_t  i_wdata;
	wide_sel_t   i_wsel;
	logic        o_wstall;
	logic        o_wack;
	wide_data_t  o_wdata;
	logic        o_werr;
	logic        o_scyc;
	logic        o_sstb;
	logic        o_swe;
	small_addr_t o_saddr;
	small_data_t o_sdata;
	small_sel_t  o_ssel;
	logic        i_sstall;
	logic        i_sack;
	small_data_t i_sdata;
	logic        i_serr;

	// Expected small beats, in issue order
	small_addr_t exp_saddr[$];
	small_data_t exp_sdata[$];
	small_sel_t  exp_ssel[$];
	logic        exp_swe[$];
	// Expected wide responses, in request order
	logic        exp_is_read[$];
	wide_data_t  exp_rdata[$];
	// Slave side read data waiting for its ack
	small_data_t ack_q[$];

	small_data_t ref_mem[MEM_WORDS];
	small_data_t slave_mem[MEM_WORDS];
	int          n_accepted;
	int          n_acked;
	int          cycle_count;
	logic        inject_err;
	logic        err_expected;
	logic        werr_seen;

	tb_clock clock_i (.o_clk(i_clk), .o_rst_n(i_rst_n));

	wbd_top dut_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_wcyc(i_wcyc), .i_wstb(i_wstb), .i_wwe(i_wwe), .i_waddr(i_waddr),
		.i_wdata(i_wdata), .i_wsel(i_wsel), .o_wstall(o_wstall), .o_wack(o_wack),
		.o_wdata(o_wdata), .o_werr(o_werr),
		.o_scyc(o_scyc), .o_sstb(o_sstb), .o_swe(o_swe), .o_saddr(o_saddr),
		.o_sdata(o_sdata), .o_ssel(o_ssel), .i_sstall(i_sstall), .i_sack(i_sack),
		.i_sdata(i_sdata), .i_serr(i_serr)
	);

	////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on failure");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
		else
			stop_with_failure($sformatf("[ERROR] %0t %s expected %h actual %h",
				$time, name, expected, actual));
	endtask

	function automatic small_data_t merge_bytes(small_data_t old_word,
		small_data_t new_word, small_sel_t sel);
		small_data_t result;
		result = old_word;
		for (int b = 0; b < SMALL_DW / 8; b++)
			if (sel[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		return result;
	endfunction

	always @(posedge i_clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
			stop_with_failure("Timeout: the traffic did not complete in time");
	end

	////////////////////////////////////////
	// Wide master
	////////////////////////////////////////

	// Upper half goes first, at sub-word zero
	task automatic record_accept();
		small_addr_t base;
		base = {i_waddr, 1'b0};
		exp_saddr.push_back(base);
		exp_saddr.push_back(base | small_addr_t'(1));
		exp_sdata.push_back(i_wdata[63:32]);
		exp_sdata.push_back(i_wdata[31:0]);
		exp_ssel.push_back(i_wsel[7:4]);
		exp_ssel.push_back(i_wsel[3:0]);
		exp_swe.push_back(i_wwe);
		exp_swe.push_back(i_wwe);
		exp_is_read.push_back(!i_wwe);
		exp_rdata.push_back({ref_mem[int'(base)], ref_mem[int'(base) + 1]});
		if (i_wwe)
		begin
			ref_mem[int'(base)] = merge_bytes(ref_mem[int'(base)], i_wdata[63:32], i_wsel[7:4]);
			ref_mem[int'(base) + 1] = merge_bytes(ref_mem[int'(base) + 1], i_wdata[31:0],
				i_wsel[3:0]);
		end
		n_accepted++;
	endtask

	task automatic issue_requests(input int count, input logic allow_writes);
		int   issued;
		logic hold;
		issued = 0;
		hold   = 1'b0;
		while (issued < count)
		begin
			@(negedge i_clk);
			if (!hold)
			begin
				i_wstb  = ($urandom_range(3) != 0);
				i_wwe   = 1'($urandom_range(1)) && allow_writes;
				i_waddr = wide_addr_t'($urandom_range(MEM_WORDS / 2 - 1));
				i_wdata = {$urandom, $urandom};
				i_wsel  = wide_sel_t'($urandom);
			end
			// Inputs and stall are settled until the next rising edge
			#1;
			hold = i_wstb && o_wstall;
			if (i_wstb && !o_wstall)
			begin
				record_accept();
				issued++;
			end
		end
		@(negedge i_clk);
		i_wstb = 1'b0;
	endtask

	// Every beat taken and acked by the slave, plus the wide ack latency
	task automatic wait_until_idle();
		while (exp_saddr.size() != 0 || ack_q.size() != 0)
			@(negedge i_clk);
		repeat (2) @(negedge i_clk);
	endtask

	task automatic wait_for_drain();
		wait_until_idle();
		check_value("wide ack count", n_accepted, n_acked);
	endtask

	////////////////////////////////////////
	// Small slave and response monitor
	////////////////////////////////////////

	task automatic accept_beat();
		int idx;
		if (exp_saddr.size() == 0)
			stop_with_failure("Small beat issued with no wide request behind it");
		check_value("o_saddr", exp_saddr.pop_front(), o_saddr);
		check_value("o_swe", exp_swe.pop_front(), o_swe);
		check_value("o_sdata", exp_sdata.pop_front(), o_sdata);
		check_value("o_ssel", exp_ssel.pop_front(), o_ssel);
		idx = int'(o_saddr);
		if (o_swe)
			slave_mem[idx] = merge_bytes(slave_mem[idx], o_sdata, o_ssel);
		ack_q.push_back(o_swe ? small_data_t'(0) : slave_mem[idx]);
	endtask

	always @(negedge i_clk)
	begin
		logic stall_now;
		stall_now = 1'b0;
		i_sack    = 1'b0;
		i_serr    = 1'b0;
		i_sdata   = $urandom;
		if (ack_q.size() > 0 && $urandom_range(2) != 0)
		begin
			if (inject_err)
			begin
				i_serr     = 1'b1;
				stall_now  = 1'b1;
				inject_err = 1'b0;
				ack_q.delete();
			end
			else
			begin
				i_sack  = 1'b1;
				i_sdata = ack_q.pop_front();
			end
		end
		i_sstall = stall_now || ($urandom_range(3) == 0);
		#1;
		if (!o_scyc)
			ack_q.delete();
		if (o_sstb && !i_sstall)
			accept_beat();
	end

	always @(negedge i_clk)
	begin
		#1;
		if (o_werr)
		begin
			if (!err_expected)
				stop_with_failure("Wide error reported with no small error injected");
			werr_seen = 1'b1;
		end
		if (o_wack)
		begin
			if (exp_rdata.size() == 0)
				stop_with_failure("Wide ack with no request outstanding");
			n_acked++;
			if (exp_is_read.pop_front())
				check_value("o_wdata", exp_rdata.pop_front(), o_wdata);
			else
				void'(exp_rdata.pop_front());
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		void'($urandom(32'h3233ee65));
		i_wcyc = 1'b0;
		i_wstb = 1'b0;
		i_wwe = 1'b0;
		i_waddr = '0;
		i_wdata = '0;
		i_wsel = '0;
		i_sstall = 1'b0;
		i_sack = 1'b0;
		i_sdata = '0;
		i_serr = 1'b0;
		n_accepted = 0;
		n_acked = 0;
		cycle_count = 0;
		inject_err = 1'b0;
		err_expected = 1'b0;
		werr_seen = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			ref_mem[i]   = 32'hc0000000 + small_data_t'(i) * 32'h00040101;
			slave_mem[i] = ref_mem[i];
		end

		@(posedge i_rst_n);
		@(negedge i_clk);
		i_wcyc = 1'b1;
		issue_requests(120, 1'b1);
		wait_for_drain();

		// One read whose first ack turns into a bus error
		err_expected = 1'b1;
		inject_err   = 1'b1;
		issue_requests(1, 1'b0);
		while (!werr_seen)
			@(negedge i_clk);
		@(negedge i_clk);
		i_wcyc = 1'b0;
		exp_saddr.delete();
		exp_sdata.delete();
		exp_ssel.delete();
		exp_swe.delete();
		exp_is_read.delete();
		exp_rdata.delete();
		n_accepted = 0;
		n_acked    = 0;
		repeat (3) @(negedge i_clk);
		err_expected = 1'b0;
		i_wcyc       = 1'b1;

		issue_requests(79, 1'b1);
		wait_until_idle();
		if (n_acked != n_accepted)
			stop_with_failure($sformatf("[ERROR] %0t wide ack count expected %0d actual %0d",
				$time, n_accepted, n_acked));
		else
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

/* bench/wbd_sva.sv */
`timescale 1ns/1ps

module wbd_sva import wbd_pkg::*;
(
	input logic        i_clk,
	input logic        i_rst_n,
	input logic        i_wcyc,
	input logic        o_wstall,
	input logic        o_wack,
	input logic        o_werr,
	input logic        o_scyc,
	input logic        o_sstb,
	input small_addr_t o_saddr,
	input small_data_t o_sdata,
	input small_sel_t  o_ssel,
	input logic        i_sstall,
	input logic        i_serr
);

	////////////////////////////////////////
	// Reset state
	////////////////////////////////////////

	a_reset_idle: assert property (@(posedge i_clk)
		!i_rst_n |=> (!o_scyc && !o_sstb && !o_wack && !o_werr && !o_wstall))
		else $error("Bus outputs active out of reset");

	////////////////////////////////////////
	// Back-pressure
	////////////////////////////////////////

	a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_sstb && i_sstall && i_wcyc && !i_serr && !o_werr)
		|=> (o_sstb && $stable(o_saddr) && $stable(o_sdata) && $stable(o_ssel)))
		else $error("Small request changed while stalled");

	a_stall_wide: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_sstb && i_sstall) |-> o_wstall)
		else $error("Wide port not stalled during small stall");

	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_sstb |-> o_scyc)
		else $error("Small strobe outside a bus cycle");

	////////////////////////////////////////
	// Error path
	////////////////////////////////////////

	a_err_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_serr && o_scyc && i_wcyc) |=> o_werr)
		else $error("Wide error missing after small error");

	// Cycle must already be gone once the error is reported
	a_err_drop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_werr |-> !o_scyc)
		else $error("Small cycle still up after wide error");

endmodule

bind wbd_top wbd_sva u_sva (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_wcyc   (i_wcyc),
	.o_wstall (o_wstall),
	.o_wack   (o_wack),
	.o_werr   (o_werr),
	.o_scyc   (o_scyc),
	.o_sstb   (o_sstb),
	.o_saddr  (o_saddr),
	.o_sdata  (o_sdata),
	.o_ssel   (o_ssel),
	.i_sstall (i_sstall),
	.i_serr   (i_serr)
);

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
	output logic o_clk,
	output logic o_rst_n
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 10;

	initial
	begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// Release on a falling edge like every other input
	initial
	begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

/* design/wbd_top.sv */
`timescale 1ns/1ps

module wbd_top import wbd_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	// Wide slave port
	input  logic        i_wcyc,
	input  logic        i_wstb,
	input  logic        i_wwe,
	input  wide_addr_t  i_waddr,
	input  wide_data_t  i_wdata,
	input  wide_sel_t   i_wsel,
	output logic        o_wstall,
	output logic        o_wack,
	output wide_data_t  o_wdata,
	output logic        o_werr,
	// Small master port
	output logic        o_scyc,
	output logic        o_sstb,
	output logic        o_swe,
	output small_addr_t o_saddr,
	output small_data_t o_sdata,
	output small_sel_t  o_ssel,
	input  logic        i_sstall,
	input  logic        i_sack,
	input  small_data_t i_sdata,
	input  logic        i_serr
);

	logic beat_push;
	logic beat_last;
	logic fifo_full;
	logic head_last;

	////////////////////////////////////////
	// Request splitting
	////////////////////////////////////////

	wbd_beat_issuer u_issuer (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_wcyc      (i_wcyc),
		.i_wstb      (i_wstb),
		.i_wwe       (i_wwe),
		.i_waddr     (i_waddr),
		.i_wdata     (i_wdata),
		.i_wsel      (i_wsel),
		.o_wstall    (o_wstall),
		.o_scyc      (o_scyc),
		.o_sstb      (o_sstb),
		.o_swe       (o_swe),
		.o_saddr     (o_saddr),
		.o_sdata     (o_sdata),
		.o_ssel      (o_ssel),
		.i_sstall    (i_sstall),
		.i_serr      (i_serr),
		.i_werr      (o_werr),
		.i_fifo_full (fifo_full),
		.o_beat_push (beat_push),
		.o_beat_last (beat_last)
	);

	////////////////////////////////////////
	// Last-beat flags of beats in flight
	////////////////////////////////////////

	wbd_ack_fifo u_fifo (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_wcyc      (i_wcyc),
		.i_push      (beat_push),
		.i_push_last (beat_last),
		.i_pop       (i_sack),
		.o_full      (fifo_full),
		.o_head_last (head_last)
	);

	////////////////////////////////////////
	// Response merging
	////////////////////////////////////////

	wbd_read_merge u_merge (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_wcyc      (i_wcyc),
		.i_scyc      (o_scyc),
		.i_sack      (i_sack),
		.i_sdata     (i_sdata),
		.i_serr      (i_serr),
		.i_head_last (head_last),
		.o_wack      (o_wack),
		.o_wdata     (o_wdata),
		.o_werr      (o_werr)
	);

endmodule

/* design/wbd_read_merge.sv */
`timescale 1ns/1ps

module wbd_read_merge import wbd_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_wcyc,
	input  logic        i_scyc,
	input  logic        i_sack,
	input  small_data_t i_sdata,
	input  logic        i_serr,
	input  logic        i_head_last,
	output logic        o_wack,
	output wide_data_t  o_wdata,
	output logic        o_werr
);

	wide_data_t r_data;
	logic       r_ack;
	logic       r_err;

	////////////////////////////////////////
	// Read data assembly
	////////////////////////////////////////

	// Each returned word enters at the bottom, so after two acks
	// the first word sits in the upper half
	always_ff @(posedge i_clk)
	begin
		if (i_sack)
			r_data <= {r_data[WIDE_DW-SMALL_DW-1:0], i_sdata};
	end

	////////////////////////////////////////
	// Wide ack and error
	////////////////////////////////////////

	// One wide ack per request, on the ack of its final beat
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || !i_wcyc || !i_scyc)
			r_ack <= 1'b0;
		else
			r_ack <= i_sack && i_head_last;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || !i_wcyc || !i_scyc)
			r_err <= 1'b0;
		else
			r_err <= i_serr;
	end

	assign o_wdata = r_data;
	assign o_wack  = r_ack;
	assign o_werr  = r_err;

endmodule

/* design/wbd_ack_fifo.sv */
`timescale 1ns/1ps

module wbd_ack_fifo import wbd_pkg::*;
(
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_wcyc,
	input  logic i_push,
	input  logic i_push_last,
	input  logic i_pop,
	output logic o_full,
	output logic o_head_last
);

	logic              mem [FIFO_DEPTH];
	logic [LGFIFO-1:0] wr_ptr;
	logic [LGFIFO-1:0] rd_ptr;
	fifo_fill_t        fill;

	logic              wr_en;
	logic              rd_en;
	logic              empty;

	assign empty  = (fill == '0);
	assign o_full = (fill == fifo_fill_t'(FIFO_DEPTH));

	// A write while full is fine when the head leaves in the same cycle
	assign wr_en = i_push && (!o_full || i_pop);
	assign rd_en = i_pop && !empty;

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= i_push_last;
	end

	assign o_head_last = mem[rd_ptr];

	////////////////////////////////////////
	// Pointers and fill level
	////////////////////////////////////////

	// Outstanding beats are forgotten once the master cycle ends
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || !i_wcyc)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;

			case ({wr_en, rd_en})
				2'b10:   fill <= fill + fifo_fill_t'(1);
				2'b01:   fill <= fill - fifo_fill_t'(1);
				default: fill <= fill;
			endcase
		end
	end

endmodule

/* design/wbd_beat_issuer.sv */
`timescale 1ns/1ps

module wbd_beat_issuer import wbd_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	// Wide request side
	input  logic        i_wcyc,
	input  logic        i_wstb,
	input  logic        i_wwe,
	input  wide_addr_t  i_waddr,
	input  wide_data_t  i_wdata,
	input  wide_sel_t   i_wsel,
	output logic        o_wstall,
	// Small request side
	output logic        o_scyc,
	output logic        o_sstb,
	output logic        o_swe,
	output small_addr_t o_saddr,
	output small_data_t o_sdata,
	output small_sel_t  o_ssel,
	input  logic        i_sstall,
	input  logic        i_serr,
	// From the read merge and the beat FIFO
	input  logic        i_werr,
	input  logic        i_fifo_full,
	// To the beat FIFO
	output logic        o_beat_push,
	output logic        o_beat_last
);

	logic        r_cyc;
	logic        r_stb;
	logic        r_we;
	small_addr_t r_addr;
	wide_data_t  s_data;
	wide_sel_t   s_sel;
	beat_cnt_t   s_count;

	logic        cyc_clear;
	logic        wide_accept;
	logic        beat_accept;

	// Abort on a dropped master cycle or on any bus error
	assign cyc_clear   = !i_wcyc || (r_cyc && i_serr) || i_werr;
	assign wide_accept = i_wstb && !o_wstall;
	assign beat_accept = o_sstb && !i_sstall;

	////////////////////////////////////////
	// Cycle tracking
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || cyc_clear)
			r_cyc <= 1'b0;
		else if (i_wstb)
			r_cyc <= 1'b1;
	end

	////////////////////////////////////////
	// Strobe, direction and beat counter
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || cyc_clear)
		begin
			r_stb   <= 1'b0;
			r_we    <= 1'b0;
			s_count <= '0;
		end
		else if (wide_accept)
		begin
			r_stb   <= 1'b1;
			r_we    <= i_wwe;
			s_count <= beat_cnt_t'(BEATS);
		end
		else if (beat_accept)
		begin
			s_count <= s_count - beat_cnt_t'(1);
			// Strobe stays up until the final beat leaves
			r_stb   <= (s_count > beat_cnt_t'(1));
		end
	end

	////////////////////////////////////////
	// Address, data and select shifter
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (wide_accept)
		begin
			// First beat always starts at sub-word zero
			r_addr <= {i_waddr, {WBLSB{1'b0}}};
			s_data <= i_wdata;
			s_sel  <= i_wsel;
		end
		else if (beat_accept)
		begin
			r_addr[WBLSB-1:0] <= r_addr[WBLSB-1:0] + WBLSB'(1);
			// Big-endian order, next word moves into the top slot
			s_data <= s_data << SMALL_DW;
			s_sel  <= s_sel << (SMALL_DW / 8);
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	assign o_scyc  = r_cyc;
	// No new beat may leave unless its ack slot can be recorded
	assign o_sstb  = r_stb && !i_fifo_full;
	assign o_swe   = r_we;
	assign o_saddr = r_addr;
	assign o_sdata = s_data[WIDE_DW-1 -: SMALL_DW];
	assign o_ssel  = s_sel[WIDE_DW/8-1 -: SMALL_DW/8];

	// Busy while a beat is blocked or more than one beat is pending
	assign o_wstall = (r_stb && (i_fifo_full || i_sstall))
		|| (s_count > beat_cnt_t'(1));

	assign o_beat_push = beat_accept;
	assign o_beat_last = (s_count == beat_cnt_t'(1));

endmodule

/* design/wbd_pkg.sv */
package wbd_pkg;

	////////////////////////////////////////
	// Bus geometry
	////////////////////////////////////////

	// Byte address width shared by both ports
	localparam int ADDRESS_WIDTH = 28;

	localparam int WIDE_DW  = 64;
	localparam int SMALL_DW = 32;

	// Word address widths after dropping the byte lane bits
	localparam int WIDE_AW  = ADDRESS_WIDTH - $clog2(WIDE_DW / 8);
	localparam int SMALL_AW = ADDRESS_WIDTH - $clog2(SMALL_DW / 8);

	// Sub-word address bits and small beats per wide request
	localparam int WBLSB = $clog2(WIDE_DW / SMALL_DW);
	localparam int BEATS = WIDE_DW / SMALL_DW;

	// Outstanding beat tracking
	localparam int LGFIFO     = 5;
	localparam int FIFO_DEPTH = 1 << LGFIFO;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [WIDE_AW-1:0]      wide_addr_t;
	typedef logic [SMALL_AW-1:0]     small_addr_t;
	typedef logic [WIDE_DW-1:0]      wide_data_t;
	typedef logic [SMALL_DW-1:0]     small_data_t;
	typedef logic [WIDE_DW/8-1:0]    wide_sel_t;
	typedef logic [SMALL_DW/8-1:0]   small_sel_t;
	typedef logic [WBLSB:0]          beat_cnt_t;
	typedef logic [LGFIFO:0]         fifo_fill_t;

endpackage
